/* rvv_cfg.svh */
`ifndef RVV_CFG_SVH
`define RVV_CFG_SVH

// datapath sizing
`define RVV_VLEN    64      // one register moves in one beat
`define RVV_XLEN    32      // scalar side
`define RVV_NUM_VEC 32

// major and minor opcodes
`define RVV_OP_V    7'h57
`define RVV_MNR_IVV 3'h0
`define RVV_MNR_MVV 3'h2
`define RVV_MNR_IVI 3'h3
`define RVV_MNR_IVX 3'h4
`define RVV_MNR_CFG 3'h7    // vsetvli

// funct6 codes of the supported ops
`define RVV_F6_ADD     6'h00
`define RVV_F6_SUB     6'h02
`define RVV_F6_AND     6'h09
`define RVV_F6_OR      6'h0a
`define RVV_F6_XOR     6'h0b
`define RVV_F6_MV      6'h17
`define RVV_F6_WXUNARY 6'h10   // vmv.x.s lives here with vs1 = 0

`endif

/* src/rvv_pkg.sv */
`default_nettype none

`include "rvv_cfg.svh"

package rvv_pkg;

    typedef logic [31:0]                     insn_t;
    typedef logic [`RVV_XLEN-1:0]            xlen_t;
    typedef logic [`RVV_VLEN-1:0]            vdata_t;
    typedef logic [$clog2(`RVV_NUM_VEC)-1:0] vreg_addr_t;
    typedef logic [1:0]                      sew_t;     // 0 is e8 up to 3 is e64
    typedef logic [7:0]                      vl_t;      // element count

    // lane ops, vd = opb op opa
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_MV,         // vd = opa
        ALU_MV_X_S      // element 0 of opb to the scalar side
    } alu_op_e;

    // issue to alu stage 1
    typedef struct packed {
        alu_op_e    op;
        sew_t       sew;
        vreg_addr_t vd;
        vdata_t     opa;    // vs1, splatted rs1 or splatted imm
        vdata_t     opb;    // vs2
    } alu_req_t;

    // alu result, to regfile or scalar port
    typedef struct packed {
        logic       valid;
        logic       to_scalar;
        vreg_addr_t vd;
        vdata_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* src/vec_scoreboard.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_cfg.svh"

module vec_scoreboard
    import rvv_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire vreg_addr_t vs1,
    input  wire vreg_addr_t vs2,
    input  wire vreg_addr_t vd,
    input  wire             uses_vs1,
    input  wire             uses_vs2,
    input  wire             writes_vd,
    input  wire             issue,
    input  wire wb_t        wb,
    output logic            hazard,
    output logic            sb_empty
);

    logic [`RVV_NUM_VEC-1:0] busy;
    logic [`RVV_NUM_VEC-1:0] set_vec;
    logic [`RVV_NUM_VEC-1:0] clr_vec;

    always_comb begin
        for (int i = 0; i < `RVV_NUM_VEC; i++) begin
            set_vec[i] = issue && writes_vd && vd == vreg_addr_t'(i);
            clr_vec[i] = wb.valid && !wb.to_scalar && wb.vd == vreg_addr_t'(i); // regfile write only
        end
    end

    // raw on either source, waw on the destination
    assign hazard   = (uses_vs1 & busy[vs1]) | (uses_vs2 & busy[vs2]) | (writes_vd & busy[vd]);
    assign sb_empty = ~|busy;

    always_ff @(posedge clk) begin
        if (!rst_n) busy <= '0;
        else        busy <= (busy | set_vec) & ~clr_vec;
    end

endmodule

`default_nettype wire

/* src/vcfg_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_cfg.svh"

module vcfg_unit
    import rvv_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         cfg_we,
    input  wire         cfg_rs1_zero,
    input  wire         cfg_rd_zero,
    input  wire sew_t   cfg_vsew,
    input  wire xlen_t  cfg_avl,
    output sew_t        sew,
    output vl_t         vl,
    output logic        cfg_valid       // one pulse, vl already updated
);

    vl_t vlmax;
    vl_t vl_nxt;

    // elements per register at the requested sew
    assign vlmax = vl_t'(`RVV_VLEN / 8) >> cfg_vsew;

    always_comb begin
        if (!cfg_rs1_zero)
            vl_nxt = (cfg_avl < xlen_t'(vlmax)) ? vl_t'(cfg_avl) : vlmax;
        else if (!cfg_rd_zero)
            vl_nxt = vlmax;             // rs1 = x0 asks for vlmax
        else
            vl_nxt = vl;                // both x0 keeps vl
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sew       <= 2'd0;      // e8
            vl        <= '0;
            cfg_valid <= 1'b0;
        end else begin
            cfg_valid <= cfg_we;
            if (cfg_we) begin
                sew <= cfg_vsew;
                vl  <= vl_nxt;
            end
        end
    end

endmodule

`default_nettype wire

/* src/vec_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_cfg.svh"

module vec_regfile
    import rvv_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire vreg_addr_t rd_addr_1,
    input  wire vreg_addr_t rd_addr_2,
    output vdata_t          rd_data_1,
    output vdata_t          rd_data_2,
    input  wire wb_t        wb
);

    vdata_t regs [`RVV_NUM_VEC];

    // async reads, issue samples them in the fetch cycle
    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RVV_NUM_VEC; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && !wb.to_scalar) begin
            regs[wb.vd] <= wb.data;     // whole register, no tail handling
        end
    end

endmodule

`default_nettype wire

/* src/vec_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_cfg.svh"

module vec_alu
    import rvv_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire alu_req_t   req,
    input  wire             req_valid,
    output wb_t             wb
);

    alu_req_t s1_req;
    logic     s1_valid;
    vdata_t   result;
    xlen_t    elem0;

    // byte-sliced adder, carry chain cut at every lane start
    function automatic vdata_t lane_addsub(vdata_t b, vdata_t a, sew_t s, logic sub);
        vdata_t     a_x;
        vdata_t     r;
        logic [8:0] part;
        logic       c;
        a_x = sub ? ~a : a;     // b - a as b + ~a + 1
        c   = sub;
        for (int i = 0; i < `RVV_VLEN/8; i++) begin
            if (i % (1 << s) == 0) c = sub;
            part          = {1'b0, b[i*8 +: 8]} + {1'b0, a_x[i*8 +: 8]} + {8'b0, c};
            r[i*8 +: 8]   = part[7:0];
            c             = part[8];
        end
        return r;
    endfunction

    // element 0 sign extended, low half only at e64
    always_comb begin
        case (s1_req.sew)
            2'd0:    elem0 = {{(`RVV_XLEN-8){s1_req.opb[7]}}, s1_req.opb[7:0]};
            2'd1:    elem0 = {{(`RVV_XLEN-16){s1_req.opb[15]}}, s1_req.opb[15:0]};
            default: elem0 = s1_req.opb[`RVV_XLEN-1:0];
        endcase
    end

    always_comb begin
        case (s1_req.op)
            ALU_ADD: result = lane_addsub(s1_req.opb, s1_req.opa, s1_req.sew, 1'b0);
            ALU_SUB: result = lane_addsub(s1_req.opb, s1_req.opa, s1_req.sew, 1'b1);
            ALU_AND: result = s1_req.opb & s1_req.opa;
            ALU_OR:  result = s1_req.opb | s1_req.opa;
            ALU_XOR: result = s1_req.opb ^ s1_req.opa;
            ALU_MV:  result = s1_req.opa;
            default: result = {{(`RVV_VLEN-`RVV_XLEN){1'b0}}, elem0};
        endcase
    end

    // stage 1 operands, stage 2 result, no stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
            wb.valid <= s1_valid;
        end
        s1_req       <= req;
        wb.to_scalar <= s1_req.op == ALU_MV_X_S;   // goes to scalar_out
        wb.vd        <= s1_req.vd;
        wb.data      <= result;
    end

endmodule

`default_nettype wire

/* src/rvv_issue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_cfg.svh"

module rvv_issue
    import rvv_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire insn_t  insn,
    input  wire         insn_valid,
    input  wire xlen_t  scalar_in,
    output logic        proc_rdy,
    output vreg_addr_t  vs1,
    output vreg_addr_t  vs2,
    output vreg_addr_t  vd,
    output logic        uses_vs1,
    output logic        uses_vs2,
    output logic        writes_vd,
    input  wire         hazard,
    input  wire         sb_empty,
    input  wire sew_t   sew,
    input  wire vdata_t rd_data_1,
    input  wire vdata_t rd_data_2,
    output alu_req_t    req,
    output logic        req_valid,
    output logic        cfg_we,
    output logic        cfg_rs1_zero,
    output logic        cfg_rd_zero,
    output sew_t        cfg_vsew,
    output xlen_t       cfg_avl
);

    insn_t      fetch_insn;
    logic       fetch_valid;
    xlen_t      fetch_rs1;
    logic       xs_pend;        // vmv.x.s sitting in alu stage 1
    logic [2:0] mnr;
    logic [5:0] funct6;
    logic       is_cfg;
    logic       op_ok;
    alu_op_e    alu_op;
    logic       stall;
    vdata_t     opa;

    // replicate the low sew bits across all lanes
    function automatic vdata_t splat(sew_t s, vdata_t v);
        case (s)
            2'd0:    return {(`RVV_VLEN/8){v[7:0]}};
            2'd1:    return {(`RVV_VLEN/16){v[15:0]}};
            2'd2:    return {(`RVV_VLEN/32){v[31:0]}};
            default: return v;
        endcase
    endfunction

    // field decode
    assign mnr    = fetch_insn[14:12];
    assign funct6 = fetch_insn[31:26];
    assign vd     = fetch_insn[11:7];
    assign vs1    = fetch_insn[19:15];      // also rs1 index or simm5
    assign vs2    = fetch_insn[24:20];
    assign is_cfg = fetch_insn[6:0] == `RVV_OP_V && mnr == `RVV_MNR_CFG && !fetch_insn[31];

    always_comb begin
        alu_op = ALU_ADD;
        op_ok  = 1'b0;
        if (fetch_insn[6:0] == `RVV_OP_V) begin
            case (mnr)
                `RVV_MNR_IVV, `RVV_MNR_IVX, `RVV_MNR_IVI: begin
                    op_ok = 1'b1;
                    case (funct6)
                        `RVV_F6_ADD: alu_op = ALU_ADD;
                        `RVV_F6_SUB: alu_op = ALU_SUB;
                        `RVV_F6_AND: alu_op = ALU_AND;
                        `RVV_F6_OR:  alu_op = ALU_OR;
                        `RVV_F6_XOR: alu_op = ALU_XOR;
                        `RVV_F6_MV:  alu_op = ALU_MV;
                        default:     op_ok  = 1'b0;     // dropped silently
                    endcase
                end
                `RVV_MNR_MVV: begin
                    alu_op = ALU_MV_X_S;
                    op_ok  = funct6 == `RVV_F6_WXUNARY && vs1 == '0;
                end
                default: op_ok = 1'b0;
            endcase
        end
    end

    assign uses_vs1  = fetch_valid & op_ok & (mnr == `RVV_MNR_IVV);
    assign uses_vs2  = fetch_valid & op_ok & (alu_op != ALU_MV);
    assign writes_vd = fetch_valid & op_ok & (alu_op != ALU_MV_X_S);   // rd is scalar

    // vsetvli waits for an idle pipe so its response cannot collide
    assign stall     = fetch_valid & ((op_ok & hazard) | (is_cfg & ~(sb_empty & ~xs_pend)));
    assign proc_rdy  = ~stall;
    assign req_valid = fetch_valid & op_ok & ~hazard;
    assign cfg_we    = fetch_valid & is_cfg & sb_empty & ~xs_pend;

    assign cfg_rs1_zero = vs1 == '0;
    assign cfg_rd_zero  = vd == '0;
    assign cfg_vsew     = fetch_insn[24:23];    // vsew field of zimm
    assign cfg_avl      = fetch_rs1;

    // operand a by form
    always_comb begin
        case (mnr)
            `RVV_MNR_IVX: opa = splat(sew, {{(`RVV_VLEN-`RVV_XLEN){fetch_rs1[`RVV_XLEN-1]}},
                                            fetch_rs1});
            `RVV_MNR_IVI: opa = splat(sew, {{(`RVV_VLEN-5){vs1[4]}}, vs1});
            default:      opa = rd_data_1;
        endcase
    end

    assign req = '{op: alu_op, sew: sew, vd: vd, opa: opa, opb: rd_data_2};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
            xs_pend     <= 1'b0;
        end else begin
            if (!stall) fetch_valid <= insn_valid;     // hold while blocked
            xs_pend <= req_valid & (alu_op == ALU_MV_X_S);
        end
        if (!stall && insn_valid) begin
            fetch_insn <= insn;
            fetch_rs1  <= scalar_in;
        end
    end

endmodule

`default_nettype wire

/* src/rvv_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_cfg.svh"

module rvv_core
    import rvv_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire insn_t  insn,
    input  wire         insn_valid,
    input  wire xlen_t  scalar_in,      // rs1, sampled with insn
    output logic        proc_rdy,
    output xlen_t       scalar_out,
    output logic        scalar_valid
);

    vreg_addr_t vs1;
    vreg_addr_t vs2;
    vreg_addr_t vd;
    logic       uses_vs1;
    logic       uses_vs2;
    logic       writes_vd;
    logic       hazard;
    logic       sb_empty;
    sew_t       sew;
    vl_t        vl;
    logic       cfg_we;
    logic       cfg_rs1_zero;
    logic       cfg_rd_zero;
    sew_t       cfg_vsew;
    xlen_t      cfg_avl;
    logic       cfg_valid;
    vdata_t     rd_data_1;
    vdata_t     rd_data_2;
    alu_req_t   req;
    logic       req_valid;
    wb_t        wb;
    logic       alu_scalar_valid;

    rvv_issue u_issue (
        .clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .scalar_in(scalar_in), .proc_rdy(proc_rdy),
        .vs1(vs1), .vs2(vs2), .vd(vd),
        .uses_vs1(uses_vs1), .uses_vs2(uses_vs2), .writes_vd(writes_vd),
        .hazard(hazard), .sb_empty(sb_empty), .sew(sew),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
        .req(req), .req_valid(req_valid),
        .cfg_we(cfg_we), .cfg_rs1_zero(cfg_rs1_zero), .cfg_rd_zero(cfg_rd_zero),
        .cfg_vsew(cfg_vsew), .cfg_avl(cfg_avl)
    );

    vec_scoreboard u_scoreboard (
        .clk(clk), .rst_n(rst_n), .vs1(vs1), .vs2(vs2), .vd(vd),
        .uses_vs1(uses_vs1), .uses_vs2(uses_vs2), .writes_vd(writes_vd),
        .issue(req_valid), .wb(wb), .hazard(hazard), .sb_empty(sb_empty)
    );

    vcfg_unit u_cfg (
        .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_rs1_zero(cfg_rs1_zero),
        .cfg_rd_zero(cfg_rd_zero), .cfg_vsew(cfg_vsew), .cfg_avl(cfg_avl),
        .sew(sew), .vl(vl), .cfg_valid(cfg_valid)
    );

    // read ports hang directly off the decoded source fields
    vec_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rd_addr_1(vs1), .rd_addr_2(vs2),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2), .wb(wb)
    );

    vec_alu u_alu (.clk(clk), .rst_n(rst_n), .req(req), .req_valid(req_valid), .wb(wb));

    // two scalar sources, never in the same cycle
    assign alu_scalar_valid = wb.valid & wb.to_scalar;
    assign scalar_valid     = cfg_valid | alu_scalar_valid;
    assign scalar_out       = (cfg_valid ? xlen_t'(vl) : '0)
                            | (alu_scalar_valid ? wb.data[`RVV_XLEN-1:0] : '0);

endmodule

`default_nettype wire

/* dv/rvv_core_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_cfg.svh"

module rvv_core_asserts
    import rvv_pkg::*;
(
    input wire                    clk,
    input wire                    rst_n,
    input wire                    req_valid,
    input wire                    hazard,
    input wire                    writes_vd,
    input wire vreg_addr_t        vd,
    input wire [`RVV_NUM_VEC-1:0] busy,       // scoreboard state
    input wire                    scalar_valid
);

    // issue only on a clean scoreboard lookup
    a_no_issue_on_hazard: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !hazard)
        else $error("req_valid high while hazard is high");

    // waw stall means a busy bit is never set twice
    a_no_double_set: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && writes_vd) |-> !busy[vd])
        else $error("scoreboard set a busy bit that was already busy");

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !scalar_valid)
        else $error("scalar_valid high during reset");

endmodule

bind rvv_core rvv_core_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .hazard(hazard),
    .writes_vd(writes_vd), .vd(vd), .busy(u_scoreboard.busy), .scalar_valid(scalar_valid)
);

`default_nettype wire

/* dv/tb_rvv_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rvv_cfg.svh"

module tb_rvv_core
    import rvv_pkg::*;
();

    localparam int WAIT_LIMIT = 50;     // cycles per wait loop

    logic       clk;
    logic       rst_n;
    insn_t      insn;
    logic       insn_valid;
    xlen_t      scalar_in;
    logic       proc_rdy;
    xlen_t      scalar_out;
    logic       scalar_valid;
    integer     seed;
    int         errors;
    int         timeouts;
    int         stall_cycles = 0;
    logic [7:0] exp_vl;             // vl as the model sees it

    rvv_core DUT (
        .clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .scalar_in(scalar_in), .proc_rdy(proc_rdy),
        .scalar_out(scalar_out), .scalar_valid(scalar_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst_n && !proc_rdy) stall_cycles <= stall_cycles + 1;  // back-pressure seen
    end

    // op encoding with vm = 1 (unmasked)
    function automatic insn_t enc_op(logic [5:0] f6, logic [2:0] mnr, logic [4:0] vs2,
                                     logic [4:0] src1, logic [4:0] vd);
        return {f6, 1'b1, vs2, src1, mnr, vd, `RVV_OP_V};
    endfunction

    function automatic insn_t enc_vsetvli(logic [1:0] vsew, logic [4:0] rs1, logic [4:0] rd);
        return {1'b0, 5'b0, 1'b0, vsew, 3'b0, rs1, `RVV_MNR_CFG, rd, `RVV_OP_V};  // zimm vsew
    endfunction

    // element 0 as vmv.x.s should return it
    function automatic xlen_t sext_sew(logic [1:0] s, xlen_t v);
        case (s)
            2'd0:    return {{24{v[7]}}, v[7:0]};
            2'd1:    return {{16{v[15]}}, v[15:0]};
            default: return v;
        endcase
    endfunction

    // low 32 bits of a value splatted at sew
    function automatic xlen_t rep_low(logic [1:0] s, xlen_t v);
        case (s)
            2'd0:    return {4{v[7:0]}};
            2'd1:    return {2{v[15:0]}};
            default: return v;
        endcase
    endfunction

    function automatic xlen_t bytes_addsub(xlen_t a, xlen_t b, logic sub);
        xlen_t r;
        for (int i = 0; i < 4; i++) begin
            r[i*8 +: 8] = sub ? a[i*8 +: 8] - b[i*8 +: 8] : a[i*8 +: 8] + b[i*8 +: 8];
        end
        return r;   // no carry or borrow between bytes
    endfunction

    function automatic logic [5:0] logic_f6(int k);
        case (k)
            0:       return `RVV_F6_AND;
            1:       return `RVV_F6_OR;
            default: return `RVV_F6_XOR;
        endcase
    endfunction

    function automatic xlen_t logic_model(int k, xlen_t a, xlen_t b);
        case (k)
            0:       return a & b;
            1:       return a | b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // called on a falling edge and returns on one
    task automatic send_insn(input insn_t word, input xlen_t rs1);
        int n;
        n = 0;
        while (!proc_rdy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!proc_rdy) begin
            timeouts++;
            $display("proc_rdy stayed low, instruction %h was never accepted", word);
        end else begin
            insn       = word;
            scalar_in  = rs1;
            insn_valid = 1'b1;
            @(negedge clk);
            insn_valid = 1'b0;      // one-cycle strobe
        end
    endtask

    task automatic wait_scalar(output xlen_t val);
        int n;
        n   = 0;
        val = '0;
        while (!scalar_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (scalar_valid) val = scalar_out;
        else begin
            timeouts++;
            $display("no scalar response arrived within %0d cycles", WAIT_LIMIT);
        end
        @(negedge clk);
    endtask

    // vsetvli plus the three vl rules
    task automatic config_and_check(input logic [1:0] s, input logic [4:0] src,
                                    input logic [4:0] rd, input xlen_t avl);
        xlen_t      got;
        logic [7:0] vlmax;
        vlmax = 8'(64 / (8 << s));
        if (src != 5'd0) exp_vl = (avl < {24'b0, vlmax}) ? avl[7:0] : vlmax;
        else if (rd != 5'd0) exp_vl = vlmax;    // both x0 keeps the old vl
        send_insn(enc_vsetvli(s, src, rd), avl);
        wait_scalar(got);
        check_value("scalar_out (vl)", got, {24'b0, exp_vl});
    endtask

    task automatic set_element_width(input logic [1:0] s);
        config_and_check(s, 5'd0, 5'd1, '0);
    endtask

    task automatic read_element0(input logic [4:0] vreg, output xlen_t val);
        send_insn(enc_op(`RVV_F6_WXUNARY, `RVV_MNR_MVV, vreg, 5'd0, 5'd10), '0);
        wait_scalar(val);
    endtask

    task automatic config_rules();
        check_value("proc_rdy", xlen_t'(proc_rdy), 32'd1);
        check_value("scalar_valid", xlen_t'(scalar_valid), 32'd0);
        for (int s = 0; s < 4; s++) begin
            config_and_check(2'(s), 5'd5, 5'd1, xlen_t'((8 >> s) - 1));   // below vlmax
            config_and_check(2'(s), 5'd0, 5'd0, '0);                    // keep
            config_and_check(2'(s), 5'd5, 5'd0, xlen_t'(9 + ($random(seed) & 255)));
            config_and_check(2'(s), 5'd0, 5'd3, '0);                    // vlmax request
        end
    endtask

    task automatic scalar_round_trip();
        xlen_t r;
        xlen_t got;
        for (int s = 0; s < 4; s++) begin
            set_element_width(2'(s));
            r = $random(seed) | 32'h0000_8080;    // e8 and e16 element 0 negative
            send_insn(enc_op(`RVV_F6_MV, `RVV_MNR_IVX, 5'd0, 5'd5, 5'd1), r);   // vmv.v.x
            read_element0(5'd1, got);
            check_value("scalar_out (vmv.x.s)", got, sext_sew(2'(s), r));
        end
    endtask

    task automatic lane_carry_isolation();
        xlen_t a;
        xlen_t b;
        xlen_t got;
        a = $random(seed) | 32'h8080_8080;     // every byte sum carries out
        b = $random(seed) | 32'h8080_8080;
        set_element_width(2'd3);
        send_insn(enc_op(`RVV_F6_MV, `RVV_MNR_IVX, 5'd0, 5'd5, 5'd2), a);
        send_insn(enc_op(`RVV_F6_MV, `RVV_MNR_IVX, 5'd0, 5'd5, 5'd3), b);
        set_element_width(2'd0);
        send_insn(enc_op(`RVV_F6_ADD, `RVV_MNR_IVV, 5'd2, 5'd3, 5'd4), '0);
        send_insn(enc_op(`RVV_F6_SUB, `RVV_MNR_IVV, 5'd2, 5'd3, 5'd5), '0);   // v2 - v3
        set_element_width(2'd3);
        read_element0(5'd4, got);
        check_value("scalar_out (vadd.vv e8)", got, bytes_addsub(a, b, 1'b0));
        read_element0(5'd5, got);
        check_value("scalar_out (vsub.vv e8)", got, bytes_addsub(a, b, 1'b1));
    endtask

    task automatic logic_ops_forms();
        xlen_t      base;
        xlen_t      xval;
        xlen_t      got;
        logic [4:0] imm;
        base = $random(seed);
        set_element_width(2'd3);
        send_insn(enc_op(`RVV_F6_MV, `RVV_MNR_IVX, 5'd0, 5'd5, 5'd6), base);
        for (int s = 0; s < 3; s++) begin
            set_element_width(2'(s));
            xval = $random(seed);
            imm  = 5'h10 | 5'($random(seed) & 15);    // always negative
            for (int k = 0; k < 3; k++) begin
                send_insn(enc_op(logic_f6(k), `RVV_MNR_IVX, 5'd6, 5'd5, 5'(7 + k)), xval);
                send_insn(enc_op(logic_f6(k), `RVV_MNR_IVI, 5'd6, imm, 5'(10 + k)), '0);
            end
            set_element_width(2'd3);     // read two or four lanes at once
            for (int k = 0; k < 3; k++) begin
                read_element0(5'(7 + k), got);
                check_value("scalar_out (logic .vx)", got,
                            logic_model(k, base, rep_low(2'(s), xval)));
                read_element0(5'(10 + k), got);
                check_value("scalar_out (logic .vi)", got,
                            logic_model(k, base, rep_low(2'(s), {{27{imm[4]}}, imm})));
            end
        end
    endtask

    task automatic dependent_chain();
        xlen_t x0v;
        xlen_t r1;
        xlen_t t2;
        xlen_t t5;
        xlen_t got;
        int    stalls_before;
        x0v = $random(seed);
        r1  = $random(seed);
        set_element_width(2'd2);
        stalls_before = stall_cycles;
        send_insn(enc_op(`RVV_F6_MV, `RVV_MNR_IVX, 5'd0, 5'd5, 5'd13), x0v);
        send_insn(enc_op(`RVV_F6_ADD, `RVV_MNR_IVX, 5'd13, 5'd5, 5'd14), r1);   // raw on v13
        send_insn(enc_op(`RVV_F6_XOR, `RVV_MNR_IVV, 5'd14, 5'd13, 5'd15), '0);
        send_insn(enc_op(`RVV_F6_ADD, `RVV_MNR_IVI, 5'd15, 5'h1d, 5'd16), '0);  // + (-3)
        send_insn(enc_op(`RVV_F6_AND, `RVV_MNR_IVV, 5'd16, 5'd14, 5'd17), '0);
        send_insn(enc_op(`RVV_F6_SUB, `RVV_MNR_IVV, 5'd17, 5'd13, 5'd18), '0);
        read_element0(5'd18, got);
        t2 = x0v + r1;
        t5 = (((t2 ^ x0v) + 32'hffff_fffd) & t2);
        check_value("scalar_out (chain)", got, t5 - x0v);
        assert (stall_cycles > stalls_before) else begin
            errors++;
            $display("proc_rdy never dropped while the dependent chain was issued");
        end
    endtask

    initial begin
        seed       = 32'h1af5_e8f9;
        errors     = 0;
        timeouts   = 0;
        exp_vl     = '0;
        rst_n      = 1'b0;
        insn       = '0;
        insn_valid = 1'b0;
        scalar_in  = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        config_rules();
        scalar_round_trip();
        lane_carry_isolation();
        logic_ops_forms();
        dependent_chain();
        $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
src/rvv_pkg.sv
src/vec_scoreboard.sv
src/vcfg_unit.sv
src/vec_regfile.sv
src/vec_alu.sv
src/rvv_issue.sv
src/rvv_core.sv
dv/rvv_core_asserts.sv
dv/tb_rvv_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_rvv_core -f verilog.f -o tb_rvv_core
./obj_dir/tb_rvv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "simulation stopped before its summary line"
    exit 1
fi
